//--- vlog.f
rtl/mm_pkg.sv
rtl/operand_bank.sv
rtl/result_bank.sv
rtl/mm_control.sv
rtl/operand_skew.sv
rtl/systolic_pe.sv
rtl/systolic_array.sv
rtl/mm_top.sv
dv/mm_assert.sv
dv/mm_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mm_tb -f vlog.f -o mm_sim

output=$(./obj_dir/mm_sim 2>&1) || true
echo "$output"

if grep -qx "NO ERRORS" <<< "$output"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed"
exit 1

//--- dv/mm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mm_tb
  import mm_pkg::*;
();

  localparam int SEED          = 97;
  localparam int RUN_TIMEOUT   = 100;
  localparam int CHECK_TIMEOUT = 20;
  localparam int QUIET_CYCLES  = 25;

  // Row r of a matrix is mat[r], element (r,c) is mat[r][c]
  typedef vec_t [MAT_SIZE-1:0] mat_t;

  logic      clk;
  logic      reset;
  logic      start;
  host_cmd_t host;
  logic      busy;
  logic      done;
  vec_t      rd_data;

  // Expected rows waiting for the compare process
  vec_t      exp_q[$];
  string     name_q[$];
  logic [1:0] rd_pipe;

  mm_top uut (
    .clk     (clk),
    .reset   (reset),
    .host    (host),
    .start   (start),
    .busy    (busy),
    .done    (done),
    .rd_data (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic mat_t matmul_ref(input mat_t a, input mat_t b);
    mat_t c;
    for (int r = 0; r < MAT_SIZE; r++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        c[r][j] = '0;
        for (int k = 0; k < MAT_SIZE; k++) begin
          // Element width result, wraps mod 2^16
          c[r][j] = c[r][j] + a[r][k] * b[k][j];
        end
      end
    end
    return c;
  endfunction

  function automatic mat_t identity();
    mat_t m;
    for (int r = 0; r < MAT_SIZE; r++) begin
      for (int c = 0; c < MAT_SIZE; c++) begin
        m[r][c] = (r == c) ? elem_t'(1) : elem_t'(0);
      end
    end
    return m;
  endfunction

  function automatic mat_t random_matrix(input bit near_max);
    mat_t m;
    for (int r = 0; r < MAT_SIZE; r++) begin
      for (int c = 0; c < MAT_SIZE; c++) begin
        if (near_max) begin
          m[r][c] = 16'hFFFF - elem_t'($urandom_range(15));
        end else begin
          m[r][c] = elem_t'($urandom);
        end
      end
    end
    return m;
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_vec(input string name, input vec_t expected, input vec_t actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %b, actual %b", name, expected, actual);
      abort_run();
    end
  endtask

  ////////////////////
  // Host tasks
  ////////////////////

  // A goes in by columns, B by rows
  task automatic load_matrices(input mat_t a, input mat_t b);
    vec_t col;
    for (int k = 0; k < MAT_SIZE; k++) begin
      for (int i = 0; i < MAT_SIZE; i++) begin
        col[i] = a[i][k];
      end
      @(posedge clk);
      host <= '{we_a: 1'b1, we_b: 1'b0, rd_en: 1'b0, addr: ADDR_WIDTH'(k), data: col};
      @(posedge clk);
      host <= '{we_a: 1'b0, we_b: 1'b1, rd_en: 1'b0, addr: ADDR_WIDTH'(k), data: b[k]};
    end
    @(posedge clk);
    host <= '0;
  endtask

  task automatic run_and_wait(input string name, input bit restart);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_bit({name, " busy after start"}, 1'b1, busy);
    if (restart) begin
      // Second pulse in the middle of the run
      repeat (2) @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
    end
    while (!seen) begin
      @(negedge clk);
      if (done) begin
        check_bit({name, " busy at done"}, 1'b1, busy);
        seen = 1'b1;
      end else if (cycles == RUN_TIMEOUT) begin
        $display("Timeout in %s: done never arrived after start", name);
        abort_run();
      end
      cycles++;
    end
    @(negedge clk);
    check_bit({name, " busy after done"}, 1'b0, busy);
  endtask

  task automatic read_row(input string name, input int r, input vec_t expected);
    @(posedge clk);
    host.rd_en <= 1'b1;
    host.addr  <= ADDR_WIDTH'(r);
    exp_q.push_back(expected);
    name_q.push_back(name);
    @(posedge clk);
    host.rd_en <= 1'b0;
  endtask

  task automatic read_matrix(input string name, input mat_t expected);
    int cycles;
    cycles = 0;
    for (int r = 0; r < MAT_SIZE; r++) begin
      read_row($sformatf("%s row %0d", name, r), r, expected[r]);
    end
    while (exp_q.size() != 0) begin
      if (cycles == CHECK_TIMEOUT) begin
        $display("Timeout in %s: result rows were never returned on rd_data", name);
        abort_run();
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  ////////////////////
  // Compare process
  ////////////////////

  // Tracks the two cycle read latency
  always @(posedge clk) begin
    if (reset) begin
      rd_pipe <= '0;
    end else begin
      rd_pipe <= {rd_pipe[0], host.rd_en};
    end
  end

  initial begin : compare
    forever begin
      @(negedge clk);
      if (rd_pipe[1]) begin
        if (exp_q.size() == 0) begin
          $display("Read data returned with no expected row queued");
          abort_run();
        end else begin
          check_vec(name_q.pop_front(), exp_q.pop_front(), rd_data);
        end
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    mat_t a;
    mat_t b;
    mat_t c_first;
    void'($urandom(SEED));
    reset = 1'b1;
    start = 1'b0;
    host  = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_bit("reset busy", 1'b0, busy);
    check_bit("reset done", 1'b0, done);

    // Identity times B gives B back
    a = identity();
    b = random_matrix(1'b0);
    load_matrices(a, b);
    run_and_wait("identity", 1'b0);
    read_matrix("identity", b);

    a = random_matrix(1'b0);
    b = random_matrix(1'b0);
    load_matrices(a, b);
    run_and_wait("random", 1'b0);
    read_matrix("random", matmul_ref(a, b));

    // Products and sums overflow 16 bits
    a = random_matrix(1'b1);
    b = random_matrix(1'b1);
    load_matrices(a, b);
    run_and_wait("wrap", 1'b0);
    read_matrix("wrap", matmul_ref(a, b));

    a = random_matrix(1'b0);
    b = random_matrix(1'b0);
    load_matrices(a, b);
    run_and_wait("restart", 1'b1);
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      check_bit("restart extra done", 1'b0, done);
    end
    read_matrix("restart", matmul_ref(a, b));

    // Back to back, old C survives a reload of the operands
    a = random_matrix(1'b0);
    b = random_matrix(1'b0);
    load_matrices(a, b);
    run_and_wait("first run", 1'b0);
    c_first = matmul_ref(a, b);
    read_matrix("first run", c_first);
    a = random_matrix(1'b0);
    b = random_matrix(1'b0);
    load_matrices(a, b);
    read_matrix("before second run", c_first);
    run_and_wait("second run", 1'b0);
    read_matrix("second run", matmul_ref(a, b));

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/mm_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mm_assert
  import mm_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input host_cmd_t host,
  input logic      busy,
  input logic      done
);

  // Operand banks only change between runs
  no_write_while_busy: assert property (
    @(posedge clk) disable iff (reset) busy |-> !(host.we_a || host.we_b)
  ) else $error("operand bank written while a run is active");

  // Busy has held since the clear cycle of the same run
  done_inside_run: assert property (
    @(posedge clk) disable iff (reset)
      done |-> busy && $past(busy, 2 * MAT_SIZE + FLUSH_CYCLES)
  ) else $error("done pulsed without a full busy run before it");

  // Run ends on the cycle after done
  idle_after_done: assert property (
    @(posedge clk) disable iff (reset) done |=> !busy
  ) else $error("busy still high after done");

endmodule

bind mm_top mm_assert u_assert (
  .clk   (clk),
  .reset (reset),
  .host  (host),
  .busy  (busy),
  .done  (done)
);

`default_nettype wire

//--- rtl/mm_top.sv
`timescale 1ns/1ps
`default_nettype none

module mm_top
  import mm_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  host_cmd_t host,
  input  logic      start,
  output logic      busy,
  output logic      done,
  output vec_t      rd_data
);

  logic                  clear;
  logic                  issue_valid;
  logic [ADDR_WIDTH-1:0] issue_index;
  logic                  drain_en;
  logic [ADDR_WIDTH-1:0] drain_row;
  lane_vec_t             a_lanes;
  lane_vec_t             b_lanes;
  lane_vec_t             a_edge;
  lane_vec_t             b_edge;
  vec_t                  row_sums;

  ////////////////////
  // Operand banks
  ////////////////////

  // Word k of A is column k, word k of B is row k
  operand_bank bank_a (
    .clk         (clk),
    .wr_en       (host.we_a),
    .wr_addr     (host.addr),
    .wr_data     (host.data),
    .issue_valid (issue_valid),
    .issue_index (issue_index),
    .lanes       (a_lanes)
  );

  operand_bank bank_b (
    .clk         (clk),
    .wr_en       (host.we_b),
    .wr_addr     (host.addr),
    .wr_data     (host.data),
    .issue_valid (issue_valid),
    .issue_index (issue_index),
    .lanes       (b_lanes)
  );

  // Stagger lanes before the left and top edges
  operand_skew skew_a (.clk(clk), .reset(reset), .lanes_in(a_lanes), .lanes_out(a_edge));
  operand_skew skew_b (.clk(clk), .reset(reset), .lanes_in(b_lanes), .lanes_out(b_edge));

  ////////////////////
  // Array and control
  ////////////////////

  systolic_array u_array (
    .clk       (clk),
    .reset     (reset),
    .clear     (clear),
    .a_edge    (a_edge),
    .b_edge    (b_edge),
    .drain_row (drain_row),
    .row_sums  (row_sums)
  );

  mm_control u_control (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .busy        (busy),
    .done        (done),
    .clear       (clear),
    .issue_valid (issue_valid),
    .issue_index (issue_index),
    .drain_en    (drain_en),
    .drain_row   (drain_row)
  );

  result_bank u_result (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (drain_en),
    .wr_row  (drain_row),
    .wr_data (row_sums),
    .rd_en   (host.rd_en),
    .rd_addr (host.addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

//--- rtl/systolic_array.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_array
  import mm_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clear,
  input  lane_vec_t             a_edge,
  input  lane_vec_t             b_edge,
  input  logic [ADDR_WIDTH-1:0] drain_row,
  output vec_t                  row_sums
);

  // a_bus[r][c] enters cell (r,c) from the left, b_bus[r][c] from above
  lane_t a_bus [MAT_SIZE][MAT_SIZE+1];
  lane_t b_bus [MAT_SIZE+1][MAT_SIZE];
  elem_t sums  [MAT_SIZE][MAT_SIZE];

  ////////////////////
  // Edges
  ////////////////////

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_edge
    assign a_bus[i][0] = a_edge[i];
    assign b_bus[0][i] = b_edge[i];
  end

  ////////////////////
  // Grid
  ////////////////////

  // Last column and last row outputs fall off the array
  for (genvar r = 0; r < MAT_SIZE; r++) begin : g_row
    for (genvar c = 0; c < MAT_SIZE; c++) begin : g_col
      systolic_pe pe (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .a_in  (a_bus[r][c]),
        .b_in  (b_bus[r][c]),
        .a_out (a_bus[r][c+1]),
        .b_out (b_bus[r+1][c]),
        .sum   (sums[r][c])
      );
    end
  end

  // Row select for draining
  always_comb begin
    for (int c = 0; c < MAT_SIZE; c++) begin
      row_sums[c] = sums[drain_row][c];
    end
  end

endmodule

`default_nettype wire

//--- rtl/systolic_pe.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_pe
  import mm_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,
  input  lane_t a_in,
  input  lane_t b_in,
  output lane_t a_out,
  output lane_t b_out,
  output elem_t sum
);

  elem_t product;

  // Truncated to the element width, so it wraps mod 2^16
  assign product = a_in.data * b_in.data;

  ////////////////////
  // Operand pass-through
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      a_out.valid <= 1'b0;
      b_out.valid <= 1'b0;
    end else begin
      a_out.valid <= a_in.valid;
      b_out.valid <= b_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    a_out.data <= a_in.data;
    b_out.data <= b_in.data;
  end

  // Accumulator
  always_ff @(posedge clk) begin
    if (clear) begin
      sum <= '0;
    end else if (a_in.valid) begin
      sum <= sum + product;
    end
  end

endmodule

`default_nettype wire

//--- rtl/operand_skew.sv
`timescale 1ns/1ps
`default_nettype none

module operand_skew
  import mm_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  lane_vec_t lanes_in,
  output lane_vec_t lanes_out
);

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign lanes_out[i] = lanes_in[i];
    end else begin : g_delay
      logic  [i-1:0] vld;
      elem_t         dat [i];

      // Valid chain, cleared so no stray operand reaches a cell
      always_ff @(posedge clk) begin
        if (reset) begin
          vld <= '0;
        end else begin
          vld[0] <= lanes_in[i].valid;
          for (int k = 1; k < i; k++) begin
            vld[k] <= vld[k-1];
          end
        end
      end

      always_ff @(posedge clk) begin
        dat[0] <= lanes_in[i].data;
        for (int k = 1; k < i; k++) begin
          dat[k] <= dat[k-1];
        end
      end

      assign lanes_out[i].valid = vld[i-1];
      assign lanes_out[i].data  = dat[i-1];
    end
  end

endmodule

`default_nettype wire

//--- rtl/mm_control.sv
`timescale 1ns/1ps
`default_nettype none

module mm_control
  import mm_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  output logic                  busy,
  output logic                  done,
  output logic                  clear,
  output logic                  issue_valid,
  output logic [ADDR_WIDTH-1:0] issue_index,
  output logic                  drain_en,
  output logic [ADDR_WIDTH-1:0] drain_row
);

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_CLEAR,
    PH_ISSUE,
    PH_FLUSH,
    PH_DRAIN
  } phase_t;

  phase_t                phase;
  logic [STEP_WIDTH-1:0] step;
  logic                  last_lane;
  logic                  last_flush;

  assign last_lane  = (step == STEP_WIDTH'(MAT_SIZE - 1));
  assign last_flush = (step == STEP_WIDTH'(FLUSH_CYCLES - 1));

  ////////////////////
  // Run sequencer
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= PH_IDLE;
      step  <= '0;
    end else begin
      case (phase)
        PH_IDLE: begin
          // start only counts here
          if (start) begin
            phase <= PH_CLEAR;
          end
          step <= '0;
        end
        PH_CLEAR: begin
          phase <= PH_ISSUE;
          step  <= '0;
        end
        PH_ISSUE: begin
          if (last_lane) begin
            phase <= PH_FLUSH;
            step  <= '0;
          end else begin
            step <= step + 1'b1;
          end
        end
        PH_FLUSH: begin
          // Let the last operands reach the far corner
          if (last_flush) begin
            phase <= PH_DRAIN;
            step  <= '0;
          end else begin
            step <= step + 1'b1;
          end
        end
        PH_DRAIN: begin
          if (last_lane) begin
            phase <= PH_IDLE;
            step  <= '0;
          end else begin
            step <= step + 1'b1;
          end
        end
        default: begin
          phase <= PH_IDLE;
          step  <= '0;
        end
      endcase
    end
  end

  // Decoded outputs
  assign busy        = (phase != PH_IDLE);
  assign clear       = (phase == PH_CLEAR);
  assign issue_valid = (phase == PH_ISSUE);
  assign issue_index = step[ADDR_WIDTH-1:0];
  assign drain_en    = (phase == PH_DRAIN);
  assign drain_row   = step[ADDR_WIDTH-1:0];
  assign done        = drain_en && last_lane;

endmodule

`default_nettype wire

//--- rtl/result_bank.sv
`timescale 1ns/1ps
`default_nettype none

module result_bank
  import mm_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_row,
  input  vec_t                  wr_data,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output vec_t                  rd_data
);

  vec_t mem [MAT_SIZE];
  vec_t rd_word;
  logic rd_pending;

  ////////////////////
  // Drain write
  ////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
  end

  ////////////////////
  // Host read
  ////////////////////

  // First stage, memory read and request flag
  always_ff @(posedge clk) begin
    rd_word <= mem[rd_addr];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= rd_en;
    end
  end

  // Second stage keeps the last row read until the next request
  always_ff @(posedge clk) begin
    if (rd_pending) begin
      rd_data <= rd_word;
    end
  end

endmodule

`default_nettype wire

//--- rtl/operand_bank.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bank
  import mm_pkg::*;
(
  input  logic                  clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  vec_t                  wr_data,
  input  logic                  issue_valid,
  input  logic [ADDR_WIDTH-1:0] issue_index,
  output lane_vec_t             lanes
);

  vec_t mem [MAT_SIZE];
  vec_t rd_word;
  logic rd_valid;

  // Host write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Compute read, one cycle behind the issue
  always_ff @(posedge clk) begin
    rd_word  <= mem[issue_index];
    rd_valid <= issue_valid;
  end

  // Every element leaves tagged with the issue valid
  always_comb begin
    for (int i = 0; i < MAT_SIZE; i++) begin
      lanes[i].valid = rd_valid;
      lanes[i].data  = rd_word[i];
    end
  end

endmodule

`default_nettype wire

//--- rtl/mm_pkg.sv
`default_nettype none

package mm_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Matrix dimension, also the lane count of every port
  localparam int MAT_SIZE = 4;
  localparam int DATA_WIDTH = 16;
  localparam int ADDR_WIDTH = $clog2(MAT_SIZE);

  // Bank read, then skew of the last lane, then the walk across the grid
  localparam int FLUSH_CYCLES = 1 + (MAT_SIZE - 1) + 2 * (MAT_SIZE - 1);

  // Step counter in the control block covers the longest phase
  localparam int STEP_WIDTH = $clog2(FLUSH_CYCLES + 1);

  ////////////////////
  // Types
  ////////////////////

  typedef logic [DATA_WIDTH-1:0] elem_t;

  // Lane i holds element i
  typedef elem_t [MAT_SIZE-1:0] vec_t;

  typedef struct packed {
    logic                  we_a;
    logic                  we_b;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] addr;
    vec_t                  data;
  } host_cmd_t;

  // One operand on its way through the array
  typedef struct packed {
    logic  valid;
    elem_t data;
  } lane_t;

  typedef lane_t [MAT_SIZE-1:0] lane_vec_t;

endpackage

`default_nettype wire
